// File: design/disk_cfg.svh
`ifndef DISK_CFG_SVH
`define DISK_CFG_SVH

// Page memory geometry, in 32-bit words
`define DISK_PAGE_AW 9
`define DISK_PAGE_WORDS (1 << `DISK_PAGE_AW)

// One sector of data at the bottom of the page
`define DISK_DATA_WORDS 256

// Register words at the top of the page
`define DISK_SPAR_ADDR 9'h1FE  // Sector address
`define DISK_CMSR_ADDR 9'h1FF  // Command word, cleared by the engine when done

`endif

// File: design/mem_bus_pkg.sv
`default_nettype none
`include "disk_cfg.svh"

package mem_bus_pkg;

    // One page memory access
    typedef struct packed {
        logic                     valid;
        logic                     we;
        logic [`DISK_PAGE_AW-1:0] addr;
        logic [3:0]               be;
        logic [31:0]              wdata;
    } mem_req_t;

    typedef struct packed {
        logic        rvalid;
        logic [31:0] rdata;
    } mem_rsp_t;

    // AXI4-Lite payloads, handshakes stay separate
    typedef struct packed {
        logic [31:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } axil_w_t;

    typedef struct packed {
        logic [31:0] addr;
    } axil_ar_t;

    // Block device request/stream interface
    typedef struct packed {
        logic        rd_en;
        logic        wr_en;
        logic [31:0] addr;
        logic [15:0] wr_data;
    } blk_req_t;

    typedef struct packed {
        logic        init_end;
        logic        busy;
        logic        rd_valid;
        logic [15:0] rd_data;
        logic        wr_req;
    } blk_rsp_t;

endpackage

`default_nettype wire

// File: design/disk_types_pkg.sv
`default_nettype none

package disk_types_pkg;

    typedef enum logic [2:0] {
        WAIT_INIT,   // Block device still initializing
        POLL_CMD,    // Reading CMSR until a valid opcode shows up
        FETCH_SPAR,  // Reading the sector address
        READ_XFER,   // Device to page memory
        WRITE_XFER,  // Page memory to device
        CLEAR_CMD    // Writing CMSR back to zero
    } disk_state_e;

    // Low two bits of CMSR
    typedef enum logic [1:0] {
        CMD_NONE  = 2'd0,
        CMD_READ  = 2'd1,
        CMD_WRITE = 2'd2
    } disk_cmd_e;

endpackage

`default_nettype wire

// File: design/page_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "disk_cfg.svh"

module page_ram
    import mem_bus_pkg::*;
(
    input  wire logic     clk,
    input  wire mem_req_t req,
    output logic [31:0]   rdata
);

    logic [31:0] mem [`DISK_PAGE_WORDS];

    // Read-first, one cycle latency on every accepted access
    always_ff @(posedge clk) begin
        if (req.valid) begin
            rdata <= mem[req.addr];
            if (req.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (req.be[b]) mem[req.addr][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/page_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module page_arbiter
    import mem_bus_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire mem_req_t    eng_req,
    output logic             eng_gnt,
    output mem_rsp_t         eng_rsp,
    input  wire mem_req_t    host_req,
    output logic             host_gnt,
    output mem_rsp_t         host_rsp,
    output mem_req_t         ram_req,
    input  wire logic [31:0] ram_rdata
);

    logic rd_q;       // A read was issued last cycle
    logic eng_own_q;  // ...and it came from the engine

    // Engine stream cannot stall, so it always wins
    assign eng_gnt  = eng_req.valid;
    assign host_gnt = host_req.valid && !eng_req.valid;

    assign ram_req = eng_req.valid ? eng_req : host_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_q      <= 1'b0;
            eng_own_q <= 1'b0;
        end else begin
            rd_q      <= ram_req.valid && !ram_req.we;
            eng_own_q <= eng_req.valid;
        end
    end

    // Data goes to both, rvalid only to the owner
    always_comb begin
        eng_rsp.rvalid  = rd_q && eng_own_q;
        eng_rsp.rdata   = ram_rdata;
        host_rsp.rvalid = rd_q && !eng_own_q;
        host_rsp.rdata  = ram_rdata;
    end

endmodule

`default_nettype wire

// File: design/axil_page_port.sv
`timescale 1ns/1ps
`default_nettype none
`include "disk_cfg.svh"

module axil_page_port
    import mem_bus_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     awvalid,
    output logic          awready,
    input  wire axil_aw_t aw,
    input  wire logic     wvalid,
    output logic          wready,
    input  wire axil_w_t  w,
    output logic          bvalid,
    input  wire logic     bready,
    input  wire logic     arvalid,
    output logic          arready,
    input  wire axil_ar_t ar,
    output logic          rvalid,
    input  wire logic     rready,
    output logic [31:0]   rdata,
    output mem_req_t      mem_req,
    input  wire logic     mem_gnt,
    input  wire mem_rsp_t mem_rsp
);

    typedef enum logic [2:0] {P_IDLE, P_ISSUE, P_RDATA, P_BRESP, P_RRESP} port_state_e;

    port_state_e              state;
    logic                     we_q;
    logic [`DISK_PAGE_AW-1:0] addr_q;
    logic [31:0]              wdata_q;
    logic [3:0]               strb_q;
    logic [31:0]              rdata_q;

    // Reads go first; a write needs both address and data present
    assign arready = (state == P_IDLE) && arvalid;
    assign awready = (state == P_IDLE) && !arvalid && awvalid && wvalid;
    assign wready  = awready;
    assign bvalid  = (state == P_BRESP);
    assign rvalid  = (state == P_RRESP);
    assign rdata   = rdata_q;

    always_comb begin
        mem_req.valid = (state == P_ISSUE);
        mem_req.we    = we_q;
        mem_req.addr  = addr_q;
        mem_req.be    = we_q ? strb_q : 4'h0;
        mem_req.wdata = wdata_q;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= P_IDLE;
        end else begin
            case (state)
                P_IDLE:  if (arvalid || awready) state <= P_ISSUE;
                P_ISSUE: if (mem_gnt) state <= we_q ? P_BRESP : P_RDATA;
                P_RDATA: if (mem_rsp.rvalid) state <= P_RRESP;
                P_BRESP: if (bready) state <= P_IDLE;
                P_RRESP: if (rready) state <= P_IDLE;
                default: state <= P_IDLE;
            endcase
        end
    end

    // Captured transaction and read data
    always_ff @(posedge clk) begin
        if (arready) begin
            we_q   <= 1'b0;
            addr_q <= ar.addr[`DISK_PAGE_AW+1:2];
        end else if (awready) begin
            we_q    <= 1'b1;
            addr_q  <= aw.addr[`DISK_PAGE_AW+1:2];  // Byte address, word select
            wdata_q <= w.wdata;
            strb_q  <= w.wstrb;
        end
        if (state == P_RDATA && mem_rsp.rvalid) rdata_q <= mem_rsp.rdata;
    end

endmodule

`default_nettype wire

// File: design/disk_engine.sv
`timescale 1ns/1ps
`default_nettype none
`include "disk_cfg.svh"

module disk_engine
    import mem_bus_pkg::*;
    import disk_types_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    output mem_req_t      mem_req,
    input  wire logic     mem_gnt,
    input  wire mem_rsp_t mem_rsp,
    output blk_req_t      blk_req,
    input  wire blk_rsp_t blk_rsp
);

    localparam int AW      = `DISK_PAGE_AW;
    localparam int HW_BITS = $clog2(2 * `DISK_DATA_WORDS);
    localparam logic [HW_BITS-1:0] LAST_HW = HW_BITS'(2 * `DISK_DATA_WORDS - 1);

    disk_state_e        state;
    disk_cmd_e          cmd;
    disk_cmd_e          rsp_cmd;
    mem_req_t           req_q;
    logic               rd_pend;  // Read granted, data due next cycle
    logic [HW_BITS-1:0] hcnt;     // Halfword index within the sector
    logic [AW-1:0]      word_addr;
    logic               rd_en;
    logic               wr_en;
    logic [31:0]        spar;
    logic [31:0]        xfer_word;  // Word being served to the device

    function automatic mem_req_t mem_rd(input logic [AW-1:0] a);
        mem_req_t r;
        r       = '0;
        r.valid = 1'b1;
        r.addr  = a;
        return r;
    endfunction

    function automatic mem_req_t mem_wr(input logic [AW-1:0] a, input logic [3:0] be,
                                        input logic [31:0] d);
        mem_req_t r;
        r.valid = 1'b1;
        r.we    = 1'b1;
        r.addr  = a;
        r.be    = be;
        r.wdata = d;
        return r;
    endfunction

    assign rsp_cmd   = disk_cmd_e'(mem_rsp.rdata[1:0]);
    assign word_addr = AW'(hcnt[HW_BITS-1:1]);
    assign mem_req   = req_q;

    always_comb begin
        blk_req.rd_en   = rd_en;
        blk_req.wr_en   = wr_en;
        blk_req.addr    = spar;
        blk_req.wr_data = hcnt[0] ? xfer_word[15:0] : xfer_word[31:16];  // Even halfword is upper
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= WAIT_INIT;
            cmd     <= CMD_NONE;
            req_q   <= '0;
            rd_pend <= 1'b0;
            hcnt    <= '0;
            rd_en   <= 1'b0;
            wr_en   <= 1'b0;
        end else begin
            // Accepted request leaves the bus
            if (req_q.valid && mem_gnt) begin
                req_q.valid <= 1'b0;
                rd_pend     <= !req_q.we;
            end
            if (mem_rsp.rvalid) rd_pend <= 1'b0;

            case (state)
                WAIT_INIT: if (blk_rsp.init_end) state <= POLL_CMD;
                POLL_CMD: begin
                    if (!req_q.valid && !rd_pend) req_q <= mem_rd(`DISK_CMSR_ADDR);
                    if (mem_rsp.rvalid) begin
                        cmd <= rsp_cmd;
                        if (rsp_cmd == CMD_READ || rsp_cmd == CMD_WRITE) state <= FETCH_SPAR;
                    end
                end
                FETCH_SPAR: begin
                    if (!req_q.valid && !rd_pend) req_q <= mem_rd(`DISK_SPAR_ADDR);
                    if (mem_rsp.rvalid) begin
                        hcnt <= '0;
                        if (cmd == CMD_READ) begin
                            rd_en <= 1'b1;
                            state <= READ_XFER;
                        end else begin
                            wr_en <= 1'b1;
                            req_q <= mem_rd('0);  // Prefetch word 0
                            state <= WRITE_XFER;
                        end
                    end
                end
                READ_XFER: begin
                    if (blk_rsp.busy) rd_en <= 1'b0;
                    if (blk_rsp.rd_valid) begin
                        req_q <= mem_wr(word_addr, hcnt[0] ? 4'b0011 : 4'b1100,
                                        {2{blk_rsp.rd_data}});
                        hcnt  <= hcnt + HW_BITS'(1);
                    end
                    if (!rd_en && !blk_rsp.busy && !req_q.valid) state <= CLEAR_CMD;
                end
                WRITE_XFER: begin
                    if (blk_rsp.busy) wr_en <= 1'b0;
                    if (blk_rsp.wr_req) begin
                        hcnt <= hcnt + HW_BITS'(1);
                        // Lower half just went out, fetch the next word
                        if (hcnt[0] && hcnt != LAST_HW) req_q <= mem_rd(word_addr + AW'(1));
                    end
                    if (!wr_en && !blk_rsp.busy && !req_q.valid && !rd_pend) state <= CLEAR_CMD;
                end
                CLEAR_CMD: begin
                    if (req_q.valid && mem_gnt) state <= POLL_CMD;
                    else if (!req_q.valid) req_q <= mem_wr(`DISK_CMSR_ADDR, 4'hF, 32'h0);
                end
                default: state <= WAIT_INIT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH_SPAR && mem_rsp.rvalid) spar <= mem_rsp.rdata;
        if (state == WRITE_XFER && mem_rsp.rvalid) xfer_word <= mem_rsp.rdata;
    end

endmodule

`default_nettype wire

// File: design/disk_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module disk_subsystem_top
    import mem_bus_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     awvalid,
    output logic          awready,
    input  wire axil_aw_t aw,
    input  wire logic     wvalid,
    output logic          wready,
    input  wire axil_w_t  w,
    output logic          bvalid,
    input  wire logic     bready,
    input  wire logic     arvalid,
    output logic          arready,
    input  wire axil_ar_t ar,
    output logic          rvalid,
    input  wire logic     rready,
    output logic [31:0]   rdata,
    output blk_req_t      blk_req,
    input  wire blk_rsp_t blk_rsp
);

    mem_req_t    host_req;
    logic        host_gnt;
    mem_rsp_t    host_rsp;
    mem_req_t    eng_req;
    logic        eng_gnt;
    mem_rsp_t    eng_rsp;
    mem_req_t    ram_req;
    logic [31:0] ram_rdata;

    axil_page_port u_port (
        .clk, .rst_n,
        .awvalid, .awready, .aw, .wvalid, .wready, .w, .bvalid, .bready,
        .arvalid, .arready, .ar, .rvalid, .rready, .rdata,
        .mem_req (host_req),
        .mem_gnt (host_gnt),
        .mem_rsp (host_rsp)
    );

    disk_engine u_engine (
        .clk, .rst_n,
        .mem_req (eng_req),
        .mem_gnt (eng_gnt),
        .mem_rsp (eng_rsp),
        .blk_req,
        .blk_rsp
    );

    page_arbiter u_arb (
        .clk, .rst_n,
        .eng_req, .eng_gnt, .eng_rsp,
        .host_req, .host_gnt, .host_rsp,
        .ram_req, .ram_rdata
    );

    page_ram u_ram (
        .clk,
        .req   (ram_req),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

// File: tb/block_dev_model.sv
`timescale 1ns/1ps
`default_nettype none

module block_dev_model
    import mem_bus_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire blk_req_t req,
    output blk_rsp_t      rsp
);

    localparam int INIT_CYCLES = 20;
    localparam int GAP         = 6;  // Cycles between stream pulses
    localparam int N_HW        = 512;

    logic [15:0] cap [N_HW];   // Halfwords received by the last write
    logic [31:0] last_addr;    // Sector of the last request
    int          req_count;
    logic        early_req;    // Request seen while still initializing
    int          init_cnt;
    int          gap_cnt;
    logic [9:0]  hw_idx;       // Pulses sent so far
    logic [8:0]  cap_idx;
    logic        rd_mode;

    function automatic logic [15:0] read_pattern(input logic [31:0] s, input logic [9:0] i);
        return {s[7:0], i[7:0]} ^ 16'h5a5a;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp       <= '0;
            last_addr <= '0;
            req_count <= 0;
            early_req <= 1'b0;
            init_cnt  <= 0;
            gap_cnt   <= 0;
            hw_idx    <= '0;
            cap_idx   <= '0;
            rd_mode   <= 1'b0;
        end else begin
            rsp.rd_valid <= 1'b0;
            rsp.wr_req   <= 1'b0;
            if (rsp.wr_req) cap_idx <= cap_idx + 9'd1;
            if (!rsp.init_end) begin
                init_cnt <= init_cnt + 1;
                if (init_cnt == INIT_CYCLES - 1) rsp.init_end <= 1'b1;
                if (req.rd_en || req.wr_en) early_req <= 1'b1;
            end else if (!rsp.busy) begin
                if (req.rd_en || req.wr_en) begin  // New sector transfer
                    rsp.busy  <= 1'b1;
                    rd_mode   <= req.rd_en;
                    last_addr <= req.addr;
                    req_count <= req_count + 1;
                    hw_idx    <= '0;
                    cap_idx   <= '0;
                    gap_cnt   <= 0;
                end
            end else if (gap_cnt == GAP - 1) begin
                gap_cnt <= 0;
                if (hw_idx == 10'(N_HW)) begin
                    rsp.busy <= 1'b0;  // One gap after the last pulse
                end else begin
                    hw_idx <= hw_idx + 10'd1;
                    if (rd_mode) begin
                        rsp.rd_valid <= 1'b1;
                        rsp.rd_data  <= read_pattern(last_addr, hw_idx);
                    end else begin
                        rsp.wr_req <= 1'b1;
                    end
                end
            end else begin
                gap_cnt <= gap_cnt + 1;
            end
        end
    end

    // wr_data is taken in the cycle of the wr_req pulse
    always_ff @(posedge clk) begin
        if (rsp.wr_req) cap[cap_idx] <= req.wr_data;
    end

endmodule

`default_nettype wire

// File: tb/tb_disk_subsystem.sv
`timescale 1ns/1ps
`default_nettype none
`include "disk_cfg.svh"

module tb_disk_subsystem
    import mem_bus_pkg::*;
();

    localparam int N_TESTS = 12;
    localparam int LIMIT   = N_TESTS * 4000;
    localparam int N_WORDS = `DISK_DATA_WORDS;
    localparam logic [31:0] SPAR_BYTE = {21'd0, `DISK_SPAR_ADDR, 2'b00};
    localparam logic [31:0] CMSR_BYTE = {21'd0, `DISK_CMSR_ADDR, 2'b00};

    typedef enum logic [2:0] {
        T_WR, T_RD, T_DREAD, T_DREAD_EARLY, T_DWRITE, T_INVALID, T_SHARED
    } op_e;

    typedef struct packed {
        op_e         op;
        logic [31:0] addr;
        logic [31:0] data;     // Write data, or sector for disk operations
        logic [3:0]  strb;
        logic [31:0] exp_val;
    } entry_t;

    logic        clk;
    logic        rst_n;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    axil_aw_t    aw;
    axil_w_t     w;
    axil_ar_t    ar;
    logic [31:0] rdata;
    blk_req_t    blk_req;
    blk_rsp_t    blk_rsp;

    entry_t      tbl [N_TESTS];
    string       tname [N_TESTS];
    logic [31:0] wr_words [N_WORDS];
    logic [31:0] lfsr;
    int          cycles = 0;

    disk_subsystem_top dut (.*);

    block_dev_model bdev (.clk, .rst_n, .req(blk_req), .rsp(blk_rsp));

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", LIMIT);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_word(output logic [31:0] v);
        for (int b = 0; b < 32; b++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // Device read pattern for halfword i of sector s
    function automatic logic [15:0] sector_hw(input logic [31:0] s, input int i);
        return {s[7:0], 8'(i)} ^ 16'h5a5a;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        logic aw_hs;
        logic w_hs;
        logic aw_done;
        logic w_done;
        @(posedge clk);
        awvalid <= 1'b1;
        aw      <= '{addr: addr};
        wvalid  <= 1'b1;
        w       <= '{wdata: data, wstrb: strb};
        aw_done = 1'b0;
        w_done  = 1'b0;
        // Address and data channels complete on their own handshakes
        while (!(aw_done && w_done)) begin
            @(negedge clk);
            aw_hs = awvalid && awready;
            w_hs  = wvalid && wready;
            @(posedge clk);
            if (aw_hs) begin
                awvalid <= 1'b0;
                aw_done = 1'b1;
            end
            if (w_hs) begin
                wvalid <= 1'b0;
                w_done = 1'b1;
            end
        end
        bready <= 1'b1;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        arvalid <= 1'b1;
        ar      <= '{addr: addr};
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        arvalid <= 1'b0;
        rready  <= 1'b1;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data = rdata;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    // Engine clears CMSR when the sector is done
    task automatic wait_cmd_done();
        logic [31:0] v;
        v = 32'hffff_ffff;
        while (v != 32'd0) axi_read(CMSR_BYTE, v);
    endtask

    task automatic disk_read(input logic [31:0] s, input string name, input bit early,
                             input bit shared);
        logic [31:0] v;
        axi_write(SPAR_BYTE, s, 4'hF);
        axi_write(CMSR_BYTE, 32'd1, 4'hF);
        @(negedge clk);
        if (early) check_eq({name, " init still pending"}, 32'd0, {31'd0, blk_rsp.init_end});
        if (shared) begin
            while (!blk_rsp.busy) @(negedge clk);
            axi_write(SPAR_BYTE, ~s, 4'hF);  // Host traffic mid-stream
            axi_read(SPAR_BYTE, v);
            check_eq({name, " SPAR during transfer"}, ~s, v);
        end
        wait_cmd_done();
        check_eq({name, " sector address"}, s, bdev.last_addr);
        if (early) check_eq({name, " request before init"}, 32'd0, {31'd0, bdev.early_req});
        for (int k = 0; k < N_WORDS; k++) begin
            axi_read(32'(k * 4), v);
            check_eq($sformatf("%s word %0d", name, k),
                     {sector_hw(s, 2 * k), sector_hw(s, 2 * k + 1)}, v);
        end
    endtask

    task automatic disk_write(input logic [31:0] s, input string name);
        logic [31:0] v;
        for (int k = 0; k < N_WORDS; k++) begin
            rand_word(v);
            wr_words[k] = v;
            axi_write(32'(k * 4), v, 4'hF);
        end
        axi_write(SPAR_BYTE, s, 4'hF);
        axi_write(CMSR_BYTE, 32'd2, 4'hF);
        wait_cmd_done();
        check_eq({name, " sector address"}, s, bdev.last_addr);
        for (int k = 0; k < N_WORDS; k++) begin
            check_eq($sformatf("%s halfword %0d", name, 2 * k),
                     {16'd0, wr_words[k][31:16]}, {16'd0, bdev.cap[2 * k]});
            check_eq($sformatf("%s halfword %0d", name, 2 * k + 1),
                     {16'd0, wr_words[k][15:0]}, {16'd0, bdev.cap[2 * k + 1]});
        end
    endtask

    task automatic invalid_cmd(input string name);
        logic [31:0] v;
        int          cnt;
        cnt = bdev.req_count;
        axi_write(CMSR_BYTE, 32'd3, 4'hF);
        repeat (200) @(posedge clk);
        axi_read(CMSR_BYTE, v);
        check_eq({name, " CMSR kept"}, 32'd3, v);
        check_eq({name, " device requests"}, 32'(cnt), 32'(bdev.req_count));
    endtask

    task automatic set_entry(input int i, input string name, input op_e op,
                             input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [31:0] exp_val);
        tbl[i]   = '{op, addr, data, strb, exp_val};
        tname[i] = name;
    endtask

    initial begin
        entry_t      e;
        logic [31:0] v;
        rst_n   = 1'b0;
        awvalid = 1'b0;
        aw      = '0;
        wvalid  = 1'b0;
        w       = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        ar      = '0;
        rready  = 1'b0;
        lfsr    = 32'h71b7_081f;

        // Entry 0 must run before the device finishes init
        set_entry(0, "init gating read", T_DREAD_EARLY, '0, 32'h13, 4'h0, '0);
        set_entry(1, "full word write", T_WR, 32'h40, 32'hdead_beef, 4'hF, '0);
        set_entry(2, "full word readback", T_RD, 32'h40, '0, 4'h0, 32'hdead_beef);
        set_entry(3, "partial strobe write", T_WR, 32'h40, 32'h1234_5678, 4'b0101, '0);
        set_entry(4, "partial strobe readback", T_RD, 32'h40, '0, 4'h0, 32'hde34_be78);
        set_entry(5, "upper address bits write", T_WR, 32'hffff_f3fc, 32'hcafe_f00d, 4'hF, '0);
        set_entry(6, "upper address bits readback", T_RD, 32'h3fc, '0, 4'h0, 32'hcafe_f00d);
        set_entry(7, "disk read", T_DREAD, '0, 32'h2a7, 4'h0, '0);
        set_entry(8, "disk write", T_DWRITE, '0, 32'h55, 4'h0, '0);
        set_entry(9, "invalid command", T_INVALID, '0, '0, 4'h0, '0);
        set_entry(10, "shared access read", T_SHARED, '0, 32'h6c, 4'h0, '0);
        set_entry(11, "second disk write", T_DWRITE, '0, 32'h1001, 4'h0, '0);

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < N_TESTS; i++) begin
            e = tbl[i];
            case (e.op)
                T_WR:          axi_write(e.addr, e.data, e.strb);
                T_RD: begin
                    axi_read(e.addr, v);
                    check_eq(tname[i], e.exp_val, v);
                end
                T_DREAD:       disk_read(e.data, tname[i], 1'b0, 1'b0);
                T_DREAD_EARLY: disk_read(e.data, tname[i], 1'b1, 1'b0);
                T_SHARED:      disk_read(e.data, tname[i], 1'b0, 1'b1);
                T_DWRITE:      disk_write(e.data, tname[i]);
                T_INVALID:     invalid_cmd(tname[i]);
                default: begin
                    $display("Table entry %0d holds an unknown operation", i);
                    $display("Simulation failed");
                    $fatal(1);
                end
            endcase
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+design
design/mem_bus_pkg.sv
design/disk_types_pkg.sv
design/page_ram.sv
design/page_arbiter.sv
design/axil_page_port.sv
design/disk_engine.sv
design/disk_subsystem_top.sv
tb/block_dev_model.sv
tb/tb_disk_subsystem.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_disk_subsystem
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation completed successfully

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard design/*.svh)

.PHONY: all run check-log clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@$(MAKE) --no-print-directory check-log LOG=$(LOG)

check-log:
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL: see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
